// ==== rtl/hps_config.svh ====
// width macros shared by the package and the RTL; include wherever a width is needed
`ifndef HPS_CONFIG_SVH
`define HPS_CONFIG_SVH

// host bus word
`define HPS_WORD_W 16

// data word position in a frame, saturates at all ones
`define HPS_IDX_W 4

// file address
`define HPS_ADDR_W 27

// joystick buttons
`define HPS_JOY_W 32

// core status word
`define HPS_STATUS_W 64

`endif

// ==== rtl/hps_pkg.sv ====
// bus word types and command codes for the host command channel; imported by each module
`default_nettype none

`include "hps_config.svh"

package hps_pkg;

	typedef logic [`HPS_WORD_W-1:0] word_t;
	typedef logic [`HPS_IDX_W-1:0]  word_idx_t;
	typedef logic [`HPS_ADDR_W-1:0] ioctl_addr_t;

	//////////////////////////////////////////////////
	// user channel, framed by io_enable
	//////////////////////////////////////////////////
	typedef enum logic [`HPS_WORD_W-1:0] {
		CMD_CFG        = 16'h0001,
		CMD_JOY0       = 16'h0002,
		CMD_JOY1       = 16'h0003,
		CMD_KBD        = 16'h0005,
		CMD_STATUS     = 16'h001E,
		CMD_STATUS_REQ = 16'h0029
	} uio_cmd_e;

	//////////////////////////////////////////////////
	// file channel, framed by fp_enable
	//////////////////////////////////////////////////
	typedef enum logic [`HPS_WORD_W-1:0] {
		// start/stop and address setup
		FIO_TX     = 16'h0053,
		// one data word per strobe
		FIO_TX_DAT = 16'h0054,
		FIO_INDEX  = 16'h0055,
		// file extension, two words
		FIO_INFO   = 16'h0056
	} fio_cmd_e;

endpackage

`default_nettype wire

// ==== rtl/io_word_framer.sv ====
// first pipeline stage: tags the command and data words of one enable-framed strobe stream
`timescale 1ns/1ps
`default_nettype none

module io_word_framer (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  enable,
	input  wire                  io_strobe,
	input  wire hps_pkg::word_t  io_din,
	output logic                 cmd_start,
	output logic                 word_valid,
	output logic                 frame_end,
	output hps_pkg::word_t       cmd,
	output hps_pkg::word_idx_t   word_idx,
	output hps_pkg::word_t       word
);
	import hps_pkg::*;

	// set once the command word of the current frame is taken
	logic      has_cmd;
	// index the next data word will carry
	word_idx_t idx_next;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_start  <= 1'b0;
			word_valid <= 1'b0;
			frame_end  <= 1'b0;
			has_cmd    <= 1'b0;
			idx_next   <= '0;
			cmd        <= '0;
			word_idx   <= '0;
			word       <= '0;
		end else begin
			cmd_start  <= 1'b0;
			word_valid <= 1'b0;
			frame_end  <= 1'b0;

			if (!enable) begin
				// only frames that carried a command report an end
				frame_end <= has_cmd;
				has_cmd   <= 1'b0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd       <= io_din;
					cmd_start <= 1'b1;
					has_cmd   <= 1'b1;
					idx_next  <= word_idx_t'(1);
				end else begin
					word       <= io_din;
					word_idx   <= idx_next;
					word_valid <= 1'b1;
					// saturate so long streams keep the last index
					if (idx_next != '1)
						idx_next <= idx_next + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/user_cmd_decoder.sv ====
// user channel decoder: config, joysticks, status writes and status-request readback
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module user_cmd_decoder (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  wire                       cmd_start,
	input  wire                       word_valid,
	input  wire                       frame_end,
	input  wire hps_pkg::word_t       cmd,
	input  wire hps_pkg::word_idx_t   word_idx,
	input  wire hps_pkg::word_t       word,
	input  wire [`HPS_STATUS_W-1:0]   status_in,
	input  wire                       status_set,
	output logic [1:0]                cfg_buttons,
	output logic                      forced_scandoubler,
	output logic                      direct_video,
	output logic [`HPS_JOY_W-1:0]     joystick_0,
	output logic [`HPS_JOY_W-1:0]     joystick_1,
	output logic [`HPS_STATUS_W-1:0]  status,
	output hps_pkg::word_t            io_dout
);
	import hps_pkg::*;

	logic                     status_set_d;
	logic [`HPS_STATUS_W-1:0] status_req;
	// counts core requests, host sees it in the low nibble
	logic [3:0]               req_cnt;

	//////////////////////////////////////////////////
	// core side status request
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status_set_d <= 1'b0;
			status_req   <= '0;
			req_cnt      <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				status_req <= status_in;
				req_cnt    <= req_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// host writes and readback
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg_buttons        <= '0;
			forced_scandoubler <= 1'b0;
			direct_video       <= 1'b0;
			joystick_0         <= '0;
			joystick_1         <= '0;
			status             <= '0;
			io_dout            <= '0;
		end else if (cmd_start) begin
			if (cmd == CMD_STATUS_REQ)
				io_dout <= {8'h00, 4'hA, req_cnt};
			else
				io_dout <= '0;
		end else if (word_valid) begin
			io_dout <= '0;
			case (cmd)
				CMD_CFG: begin
					cfg_buttons        <= word[1:0];
					forced_scandoubler <= word[4];
					direct_video       <= word[10];
				end
				CMD_JOY0: begin
					if (word_idx == 4'd1)
						joystick_0[15:0] <= word;
					else
						joystick_0[31:16] <= word;
				end
				CMD_JOY1: begin
					if (word_idx == 4'd1)
						joystick_1[15:0] <= word;
					else
						joystick_1[31:16] <= word;
				end
				// low quarter first
				CMD_STATUS: begin
					case (word_idx)
						4'd1: status[15:0]  <= word;
						4'd2: status[31:16] <= word;
						4'd3: status[47:32] <= word;
						4'd4: status[63:48] <= word;
						default: ;
					endcase
				end
				CMD_STATUS_REQ: begin
					case (word_idx)
						4'd1: io_dout <= status_req[15:0];
						4'd2: io_dout <= status_req[31:16];
						4'd3: io_dout <= status_req[47:32];
						4'd4: io_dout <= status_req[63:48];
						default: ;
					endcase
				end
				default: ;
			endcase
		end else if (frame_end) begin
			io_dout <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/ps2_key_decoder.sv ====
// user channel keyboard decoder: collects event bytes and publishes ps2_key at frame end
`timescale 1ns/1ps
`default_nettype none

module ps2_key_decoder (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  cmd_start,
	input  wire                  word_valid,
	input  wire                  frame_end,
	input  wire hps_pkg::word_t  cmd,
	input  wire hps_pkg::word_t  word,
	output logic [10:0]          ps2_key
);
	import hps_pkg::*;

	logic        kbd_frame;
	logic        skip;
	// last four bytes, newest in the low byte
	logic [31:0] raw;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	// release has F0 before the key, so look one byte further back for E0
	assign pressed  = (raw[15:8] != 8'hF0);
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_comb begin
		case (raw)
			32'hE012E07C: key_code = 10'h37C;	// print screen make
			32'h7CE0F012: key_code = 10'h17C;	// print screen break
			32'hF014F077: key_code = 10'h377;	// pause
			default:      key_code = {pressed, extended, raw[7:0]};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kbd_frame <= 1'b0;
			skip      <= 1'b0;
			raw       <= '0;
			ps2_key   <= '0;
		end else if (cmd_start) begin
			kbd_frame <= (cmd == CMD_KBD);
			skip      <= 1'b0;
			if (cmd == CMD_KBD)
				raw <= '0;
		end else if (word_valid && kbd_frame) begin
			// high byte FF marks a frame the core must ignore
			if (&word[15:8])
				skip <= 1'b1;
			else if (!skip)
				raw <= {raw[23:0], word[7:0]};
		end else if (frame_end) begin
			if (kbd_frame && !skip)
				ps2_key <= {~ps2_key[10], key_code};
			kbd_frame <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/file_transfer.sv ====
// file channel stage: index, extension, download writes and upload reads toward the core
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module file_transfer (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire                      cmd_start,
	input  wire                      word_valid,
	input  wire hps_pkg::word_t      cmd,
	input  wire hps_pkg::word_idx_t  word_idx,
	input  wire hps_pkg::word_t      word,
	input  wire [7:0]                ioctl_din,
	output logic                     ioctl_download,
	output logic                     ioctl_upload,
	output logic                     ioctl_wr,
	output logic                     ioctl_rd,
	output hps_pkg::ioctl_addr_t     ioctl_addr,
	output logic [7:0]               ioctl_dout,
	output hps_pkg::word_t           ioctl_index,
	output logic [31:0]              ioctl_file_ext,
	output hps_pkg::word_t           fp_dout
);
	import hps_pkg::*;

	// next download address; ioctl_addr shows the one just written
	ioctl_addr_t addr;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_upload   <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_rd       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			fp_dout        <= '0;
			addr           <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			ioctl_rd <= 1'b0;

			if (cmd_start) begin
				// new command, old read data no longer applies
				fp_dout <= '0;
			end else if (word_valid) begin
				case (cmd)
					FIO_INDEX: ioctl_index <= word;
					FIO_INFO: begin
						if (word_idx == 4'd1)
							ioctl_file_ext[31:16] <= word;
						else if (word_idx == 4'd2)
							ioctl_file_ext[15:0] <= word;
					end
					FIO_TX: begin
						case (word_idx)
							4'd1: begin
								if (word[7:0] == 8'hAA) begin
									ioctl_addr   <= '0;
									ioctl_upload <= 1'b1;
									ioctl_rd     <= 1'b1;
								end else if (word[7:0] != 8'h00) begin
									addr           <= '0;
									ioctl_download <= 1'b1;
								end else begin
									// leave ioctl_addr at the transfer end
									if (ioctl_download)
										ioctl_addr <= addr;
									ioctl_download <= 1'b0;
									ioctl_upload   <= 1'b0;
								end
							end
							4'd2: begin
								ioctl_addr[15:0] <= word;
								addr[15:0]       <= word;
							end
							4'd3: begin
								ioctl_addr[`HPS_ADDR_W-1:16] <= word[`HPS_ADDR_W-17:0];
								addr[`HPS_ADDR_W-1:16]       <= word[`HPS_ADDR_W-17:0];
							end
							default: ;
						endcase
					end
					FIO_TX_DAT: begin
						if (ioctl_download) begin
							ioctl_addr <= addr;
							ioctl_dout <= word[7:0];
							ioctl_wr   <= 1'b1;
							addr       <= addr + 1'b1;
						end else if (ioctl_upload) begin
							// byte at the current address, then request the next one
							fp_dout    <= {8'h00, ioctl_din};
							ioctl_addr <= ioctl_addr + 1'b1;
							ioctl_rd   <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hps_io_top.sv ====
// top level of the host command channel: two framers feeding the user and file decoders
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module hps_io_top (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire                          io_strobe,
	input  wire                          io_enable,
	input  wire                          fp_enable,
	input  wire hps_pkg::word_t          io_din,
	input  wire [`HPS_STATUS_W-1:0]      status_in,
	input  wire                          status_set,
	input  wire [7:0]                    ioctl_din,
	output wire [`HPS_JOY_W-1:0]         joystick_0,
	output wire [`HPS_JOY_W-1:0]         joystick_1,
	output wire [1:0]                    buttons,
	output wire                          forced_scandoubler,
	output wire                          direct_video,
	output wire [`HPS_STATUS_W-1:0]      status,
	output wire [10:0]                   ps2_key,
	output wire                          ioctl_download,
	output wire                          ioctl_upload,
	output wire                          ioctl_wr,
	output wire                          ioctl_rd,
	output wire hps_pkg::ioctl_addr_t    ioctl_addr,
	output wire [7:0]                    ioctl_dout,
	output wire hps_pkg::word_t          ioctl_index,
	output wire [31:0]                   ioctl_file_ext,
	output wire hps_pkg::word_t          io_dout,
	output wire hps_pkg::word_t          fp_dout
);
	import hps_pkg::*;

	wire       uio_cmd_start;
	wire       uio_word_valid;
	wire       uio_frame_end;
	word_t     uio_cmd;
	word_idx_t uio_word_idx;
	word_t     uio_word;

	wire       fio_cmd_start;
	wire       fio_word_valid;
	word_t     fio_cmd;
	word_idx_t fio_word_idx;
	word_t     fio_word;

	//////////////////////////////////////////////////
	// user channel
	//////////////////////////////////////////////////
	io_word_framer uio_framer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.enable     (io_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.cmd_start  (uio_cmd_start),
		.word_valid (uio_word_valid),
		.frame_end  (uio_frame_end),
		.cmd        (uio_cmd),
		.word_idx   (uio_word_idx),
		.word       (uio_word)
	);

	user_cmd_decoder user_dec (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.cmd_start          (uio_cmd_start),
		.word_valid         (uio_word_valid),
		.frame_end          (uio_frame_end),
		.cmd                (uio_cmd),
		.word_idx           (uio_word_idx),
		.word               (uio_word),
		.status_in          (status_in),
		.status_set         (status_set),
		.cfg_buttons        (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.io_dout            (io_dout)
	);

	ps2_key_decoder ps2_dec (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cmd_start  (uio_cmd_start),
		.word_valid (uio_word_valid),
		.frame_end  (uio_frame_end),
		.cmd        (uio_cmd),
		.word       (uio_word),
		.ps2_key    (ps2_key)
	);

	//////////////////////////////////////////////////
	// file channel, end of frame has no use here
	//////////////////////////////////////////////////
	io_word_framer fio_framer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.enable     (fp_enable),
		.io_strobe  (io_strobe),
		.io_din     (io_din),
		.cmd_start  (fio_cmd_start),
		.word_valid (fio_word_valid),
		.frame_end  (),
		.cmd        (fio_cmd),
		.word_idx   (fio_word_idx),
		.word       (fio_word)
	);

	file_transfer file_xfer (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cmd_start      (fio_cmd_start),
		.word_valid     (fio_word_valid),
		.cmd            (fio_cmd),
		.word_idx       (fio_word_idx),
		.word           (fio_word),
		.ioctl_din      (ioctl_din),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_wr       (ioctl_wr),
		.ioctl_rd       (ioctl_rd),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.fp_dout        (fp_dout)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// testbench clock and reset source: 20 ns clock, reset held high for the first three cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #HALF_PERIOD clk_sys = ~clk_sys;
	end

	// release on a falling edge, like every other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// ==== dv/hps_io_tb.sv ====
// testbench for hps_io_top: sends host frames on both channels and checks every response
`timescale 1ns/1ps
`default_nettype none

`include "hps_config.svh"

module hps_io_tb;
	import hps_pkg::*;

	localparam int N_DL = 8;
	localparam int N_UL = 6;
	// fixed frames need 49 words, the data frames add one per byte
	localparam int WORDS_TOTAL     = 49 + N_DL + N_UL;
	localparam int WATCHDOG_CYCLES = 40 * WORDS_TOTAL + 1000;

	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_IO   = 2'd1;
	localparam logic [1:0] CHK_FP   = 2'd2;
	localparam logic [1:0] CHK_WR   = 2'd3;

	wire clk_sys;
	wire reset;

	logic                     io_strobe;
	logic                     io_enable;
	logic                     fp_enable;
	word_t                    io_din;
	logic [`HPS_STATUS_W-1:0] status_in;
	logic                     status_set;
	logic [7:0]               ioctl_din = 8'h00;

	wire [`HPS_JOY_W-1:0]    joystick_0;
	wire [`HPS_JOY_W-1:0]    joystick_1;
	wire [1:0]               buttons;
	wire                     forced_scandoubler;
	wire                     direct_video;
	wire [`HPS_STATUS_W-1:0] status;
	wire [10:0]              ps2_key;
	wire                     ioctl_download;
	wire                     ioctl_upload;
	wire                     ioctl_wr;
	wire                     ioctl_rd;
	ioctl_addr_t             ioctl_addr;
	wire [7:0]               ioctl_dout;
	word_t                   ioctl_index;
	wire [31:0]              ioctl_file_ext;
	word_t                   io_dout;
	word_t                   fp_dout;

	integer seed = 65262;

	// data words of the next frame with the check each one expects
	logic [15:0] tx_words[$];
	logic [1:0]  tx_kinds[$];
	logic [63:0] tx_exps[$];

	// check tag travels with the strobe, two cycles to the result
	logic [1:0]  chk_kind;
	logic [63:0] chk_exp;
	logic [1:0]  kind_d1;
	logic [1:0]  kind_d2;
	logic [63:0] exp_d1;
	logic [63:0] exp_d2;
	int          wr_count;
	int          rd_count;

	tb_clock_gen clock_gen (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	hps_io_top uut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.ioctl_din          (ioctl_din),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_upload       (ioctl_upload),
		.ioctl_wr           (ioctl_wr),
		.ioctl_rd           (ioctl_rd),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.io_dout            (io_dout),
		.fp_dout            (fp_dout)
	);

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////
	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got == exp) else begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_flag(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopped at the first failed check");
		end
	endtask

	always @(posedge clk_sys) begin
		if (reset) begin
			kind_d1 <= CHK_NONE;
			kind_d2 <= CHK_NONE;
			exp_d1  <= '0;
			exp_d2  <= '0;
		end else begin
			kind_d1 <= io_strobe ? chk_kind : CHK_NONE;
			exp_d1  <= chk_exp;
			kind_d2 <= kind_d1;
			exp_d2  <= exp_d1;
		end
	end

	always @(negedge clk_sys) begin
		case (kind_d2)
			CHK_IO: check_value("io_dout", 64'(io_dout), exp_d2);
			CHK_FP: begin
				check_value("fp_dout", 64'(fp_dout), exp_d2);
				check_flag(ioctl_rd, "ioctl_rd did not pulse with an upload read");
			end
			CHK_WR: begin
				check_flag(ioctl_wr, "ioctl_wr did not pulse with a download word");
				check_value("ioctl_addr", 64'(ioctl_addr), 64'(exp_d2[34:8]));
				check_value("ioctl_dout", 64'(ioctl_dout), 64'(exp_d2[7:0]));
			end
			default: ;
		endcase
	end

	// pulse counters and the core's read data
	always @(negedge clk_sys) begin
		if (ioctl_wr)
			wr_count <= wr_count + 1;
		if (ioctl_rd)
			rd_count <= rd_count + 1;
		ioctl_din <= ioctl_addr[7:0] ^ 8'h5A;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	//////////////////////////////////////////////////
	// bus driver
	//////////////////////////////////////////////////
	task automatic queue_word(input logic [15:0] w, input logic [1:0] kind,
			input logic [63:0] exp);
		tx_words.push_back(w);
		tx_kinds.push_back(kind);
		tx_exps.push_back(exp);
	endtask

	// called on a falling edge, returns on one
	task automatic strobe_word(input logic [15:0] w, input logic [1:0] kind,
			input logic [63:0] exp);
		logic [1:0] gap;
		io_din    = w;
		io_strobe = 1'b1;
		chk_kind  = kind;
		chk_exp   = exp;
		@(negedge clk_sys);
		io_strobe = 1'b0;
		chk_kind  = CHK_NONE;
		gap = 2'($random(seed));
		repeat (gap) @(negedge clk_sys);
	endtask

	task automatic send_frame(input logic file_ch, input logic [15:0] cmd_word,
			input logic [1:0] cmd_kind, input logic [63:0] cmd_exp);
		if (file_ch)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		@(negedge clk_sys);
		strobe_word(cmd_word, cmd_kind, cmd_exp);
		while (tx_words.size() > 0)
			strobe_word(tx_words.pop_front(), tx_kinds.pop_front(), tx_exps.pop_front());
		io_enable = 1'b0;
		fp_enable = 1'b0;
		// frame end and the last result settle
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic write_joystick(input logic [15:0] cmd_word, input logic [31:0] val);
		queue_word(val[15:0], CHK_NONE, '0);
		queue_word(val[31:16], CHK_NONE, '0);
		send_frame(1'b0, cmd_word, CHK_NONE, '0);
	endtask

	task automatic pulse_status_set(input logic [63:0] value);
		status_in  = value;
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
		@(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	initial begin : stimulus
		logic [15:0] cfg_word;
		logic [31:0] joy0_val;
		logic [31:0] joy1_val;
		logic [63:0] status_val;
		logic [63:0] req_val;
		logic [3:0]  req_pulses;
		logic [15:0] file_index;
		logic [26:0] base_addr;
		logic [15:0] data_word;
		logic [15:0] ext_hi;
		logic [15:0] ext_lo;
		logic [10:0] key_exp;
		int          i;

		io_strobe  = 1'b0;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		chk_kind   = CHK_NONE;
		chk_exp    = '0;

		// reset changes on a falling edge, so look for its release on a rising one
		@(posedge clk_sys);
		while (reset)
			@(posedge clk_sys);
		@(negedge clk_sys);

		check_value("ioctl_wr", 64'(ioctl_wr), 64'd0);
		check_value("ioctl_rd", 64'(ioctl_rd), 64'd0);
		check_value("ioctl_download", 64'(ioctl_download), 64'd0);
		check_value("ioctl_upload", 64'(ioctl_upload), 64'd0);
		check_value("io_dout", 64'(io_dout), 64'd0);

		// configuration and joysticks
		cfg_word = 16'($random(seed));
		queue_word(cfg_word, CHK_NONE, '0);
		send_frame(1'b0, CMD_CFG, CHK_NONE, '0);
		check_value("buttons", 64'(buttons), 64'(cfg_word[1:0]));
		check_value("forced_scandoubler", 64'(forced_scandoubler), 64'(cfg_word[4]));
		check_value("direct_video", 64'(direct_video), 64'(cfg_word[10]));

		joy0_val = 32'($random(seed));
		joy1_val = 32'($random(seed));
		write_joystick(CMD_JOY0, joy0_val);
		write_joystick(CMD_JOY1, joy1_val);
		check_value("joystick_0", 64'(joystick_0), 64'(joy0_val));
		check_value("joystick_1", 64'(joystick_1), 64'(joy1_val));

		// status write, low quarter first
		status_val = {32'($random(seed)), 32'($random(seed))};
		for (i = 0; i < 4; i++)
			queue_word(status_val[16*i +: 16], CHK_NONE, '0);
		send_frame(1'b0, CMD_STATUS, CHK_NONE, '0);
		check_value("status", status, status_val);

		// core status requests and readback
		req_pulses = 4'($random(seed));
		if (req_pulses == 4'd0)
			req_pulses = 4'd1;
		req_val = '0;
		for (i = 0; i < int'(req_pulses); i++) begin
			req_val = {32'($random(seed)), 32'($random(seed))};
			pulse_status_set(req_val);
		end
		for (i = 0; i < 4; i++)
			queue_word(16'h0000, CHK_IO, 64'(req_val[16*i +: 16]));
		send_frame(1'b0, CMD_STATUS_REQ, CHK_IO, 64'(16'h00A0 + 16'(req_pulses)));
		check_value("io_dout", 64'(io_dout), 64'd0);

		//////////////////////////////////////////////////
		// keyboard events
		//////////////////////////////////////////////////
		key_exp = '0;
		// plain make: pressed, not extended
		queue_word(16'h001C, CHK_NONE, '0);
		send_frame(1'b0, CMD_KBD, CHK_NONE, '0);
		key_exp = {~key_exp[10], 1'b1, 1'b0, 8'h1C};
		check_value("ps2_key", 64'(ps2_key), 64'(key_exp));

		// extended break: released, extended
		queue_word(16'h00E0, CHK_NONE, '0);
		queue_word(16'h00F0, CHK_NONE, '0);
		queue_word(16'h0075, CHK_NONE, '0);
		send_frame(1'b0, CMD_KBD, CHK_NONE, '0);
		key_exp = {~key_exp[10], 1'b0, 1'b1, 8'h75};
		check_value("ps2_key", 64'(ps2_key), 64'(key_exp));

		// print screen make
		queue_word(16'h00E0, CHK_NONE, '0);
		queue_word(16'h0012, CHK_NONE, '0);
		queue_word(16'h00E0, CHK_NONE, '0);
		queue_word(16'h007C, CHK_NONE, '0);
		send_frame(1'b0, CMD_KBD, CHK_NONE, '0);
		key_exp = {~key_exp[10], 10'h37C};
		check_value("ps2_key", 64'(ps2_key), 64'(key_exp));

		queue_word(16'h0011, CHK_NONE, '0);
		queue_word(16'hFF00, CHK_NONE, '0);
		send_frame(1'b0, CMD_KBD, CHK_NONE, '0);
		check_value("ps2_key", 64'(ps2_key), 64'(key_exp));

		//////////////////////////////////////////////////
		// download into the core
		//////////////////////////////////////////////////
		file_index = 16'($random(seed));
		queue_word(file_index, CHK_NONE, '0);
		send_frame(1'b1, FIO_INDEX, CHK_NONE, '0);
		check_value("ioctl_index", 64'(ioctl_index), 64'(file_index));

		base_addr = 27'($random(seed));
		queue_word(16'h0001, CHK_NONE, '0);
		queue_word(base_addr[15:0], CHK_NONE, '0);
		queue_word({5'b00000, base_addr[26:16]}, CHK_NONE, '0);
		send_frame(1'b1, FIO_TX, CHK_NONE, '0);
		check_value("ioctl_download", 64'(ioctl_download), 64'd1);

		for (i = 0; i < N_DL; i++) begin
			data_word = 16'($random(seed));
			queue_word(data_word, CHK_WR, 64'({base_addr + 27'(i), data_word[7:0]}));
		end
		send_frame(1'b1, FIO_TX_DAT, CHK_NONE, '0);
		check_value("ioctl_wr pulses", 64'(wr_count), 64'(N_DL));

		queue_word(16'h0000, CHK_NONE, '0);
		send_frame(1'b1, FIO_TX, CHK_NONE, '0);
		check_value("ioctl_download", 64'(ioctl_download), 64'd0);

		//////////////////////////////////////////////////
		// upload from the core
		//////////////////////////////////////////////////
		queue_word(16'h00AA, CHK_NONE, '0);
		send_frame(1'b1, FIO_TX, CHK_NONE, '0);
		check_value("ioctl_upload", 64'(ioctl_upload), 64'd1);
		check_value("ioctl_rd pulses", 64'(rd_count), 64'd1);

		// reads start at address 0
		for (i = 0; i < N_UL; i++)
			queue_word(16'($random(seed)), CHK_FP, 64'({8'h00, 8'(i) ^ 8'h5A}));
		send_frame(1'b1, FIO_TX_DAT, CHK_NONE, '0);
		check_value("ioctl_rd pulses", 64'(rd_count), 64'(N_UL + 1));

		queue_word(16'h0000, CHK_NONE, '0);
		send_frame(1'b1, FIO_TX, CHK_NONE, '0);
		check_value("ioctl_upload", 64'(ioctl_upload), 64'd0);

		ext_hi = 16'($random(seed));
		ext_lo = 16'($random(seed));
		queue_word(ext_hi, CHK_NONE, '0);
		queue_word(ext_lo, CHK_NONE, '0);
		send_frame(1'b1, FIO_INFO, CHK_NONE, '0);
		check_value("ioctl_file_ext", 64'(ioctl_file_ext), 64'({ext_hi, ext_lo}));

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/hps_pkg.sv
rtl/io_word_framer.sv
rtl/user_cmd_decoder.sv
rtl/ps2_key_decoder.sv
rtl/file_transfer.sv
rtl/hps_io_top.sv
dv/tb_clock_gen.sv
dv/hps_io_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= hps_io_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
